// File: Makefile
# Verilator build for the UART string link testbench.

TOP := tb_uart_string_handle

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-Mdir obj_dir -f filelist.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: filelist.f
verilog/uart_string_pkg.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/string_framer_tx.sv
verilog/string_framer_rx.sv
verilog/uart_string_handle.sv
test/uart_string_checker.sv
test/tb_uart_string_handle.sv

// File: test/tb_uart_string_handle.sv
// ----------------------------------------------------------------------
// Testbench for the UART string link.
// Clock, reset, serial driver, line monitor, reference model,
// result comparison and the directed and random tests.
// ----------------------------------------------------------------------
`default_nettype none

module tb_uart_string_handle import uart_string_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	typedef logic [7:0] byte_q_t [$];

	localparam int DRIVE_DELAY = 5;
	localparam int BIT_CLKS = 87;
	localparam int MAX_BYTES = 137;
	localparam logic [7:0] DELIM = 8'h26;
	localparam int QUIET_CLKS = 3 * 11 * BIT_CLKS;
	// Twice about 185 bytes of about 960 cycles plus a quiet gap.
	localparam int TIMEOUT_CYCLES = 400000;

	logic sys_clk;
	logic sys_rst_n;
	logic [STR_W-1:0] tx_string;
	logic [LEN_W-1:0] tx_length;
	logic tx_req;
	logic tx_busy;
	logic tx_done;
	logic [STR_W-1:0] rx_string;
	logic [LEN_W-1:0] rx_length;
	logic rx_busy;
	logic rx_done;
	logic uart_rx_port;
	logic uart_tx_port;

	logic loop_sel;
	logic drv_line;
	integer seed;
	string test_name;
	int tx_count = 0;
	int rx_count = 0;
	byte_q_t tx_seen;
	logic [STR_W-1:0] exp_str [$];
	int exp_len [$];

	// Loopback or bit-banged serial input.
	assign uart_rx_port = loop_sel ? uart_tx_port : drv_line;

	uart_string_handle DUT (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			abort_run($sformatf("ERROR %s %s: expected 0x%0h, actual 0x%0h",
				test_name, what, expected, actual));
		end
	endtask

	function automatic void append_byte(inout logic [STR_W-1:0] str, inout int len,
			input logic [7:0] c);
		if (len < MAX_BYTES) begin
			str[8*len +: 8] = c;
			len = len + 1;
		end
	endfunction

	// Receive rules applied to the first frame of a byte stream.
	function automatic void expected_rx(input byte_q_t stream,
			output logic [STR_W-1:0] str, output int len);
		int st;
		logic [7:0] c;
		st = 0;
		len = 0;
		str = '0;
		foreach (stream[i]) begin
			c = stream[i];
			case (st)
				0: if (c == DELIM) st = 1;
				1: st = (c == DELIM) ? 2 : 0;
				2: if (c == DELIM) st = 3; else append_byte(str, len, c);
				3: begin
					if (c == DELIM) begin
						st = 4;
					end else begin
						// Lone delimiter is data.
						append_byte(str, len, DELIM);
						append_byte(str, len, c);
						st = 2;
					end
				end
				default: ;
			endcase
		end
	endfunction

	function automatic byte_q_t text_bytes(input string s);
		byte_q_t q;
		for (int i = 0; i < s.len(); i++) begin
			q.push_back(s[i]);
		end
		return q;
	endfunction

	function automatic byte_q_t framed_line(input byte_q_t content);
		byte_q_t q;
		q = {DELIM, DELIM};
		foreach (content[i]) q.push_back(content[i]);
		q.push_back(DELIM);
		q.push_back(DELIM);
		return q;
	endfunction

	task automatic drive_bit(input logic level);
		@(posedge sys_clk);
		#DRIVE_DELAY;
		drv_line = level;
		repeat (BIT_CLKS - 1) @(posedge sys_clk);
	endtask

	task automatic drive_byte(input logic [7:0] data);
		drive_bit(1'b0);
		for (int i = 0; i < 8; i++) drive_bit(data[i]);
		drive_bit(1'b1);
	endtask

	task automatic compare_line(input byte_q_t line);
		check_value("line byte count", line.size(), tx_seen.size());
		foreach (line[i]) check_value($sformatf("line byte %0d", i), line[i], tx_seen[i]);
	endtask

	// One frame in loopback with an optional request while busy.
	task automatic run_loopback(input string name, input byte_q_t content,
			input logic busy_req);
		byte_q_t line;
		logic [STR_W-1:0] es;
		int el;
		int rx_target;
		int tx_target;
		test_name = name;
		line = framed_line(content);
		expected_rx(line, es, el);
		exp_str.push_back(es);
		exp_len.push_back(el);
		tx_seen.delete();
		rx_target = rx_count + 1;
		tx_target = tx_count + 1;
		@(posedge sys_clk);
		#DRIVE_DELAY;
		tx_string = '0;
		foreach (content[i]) tx_string[8*i +: 8] = content[i];
		tx_length = LEN_W'(content.size());
		tx_req = 1'b1;
		@(posedge sys_clk);
		#DRIVE_DELAY;
		tx_req = 1'b0;
		if (busy_req) begin
			repeat (100) @(posedge sys_clk);
			#DRIVE_DELAY;
			check_value("tx_busy", 1, tx_busy);
			tx_string = '1;
			tx_length = LEN_W'(4);
			tx_req = 1'b1;
			@(posedge sys_clk);
			#DRIVE_DELAY;
			tx_req = 1'b0;
		end
		wait (rx_count == rx_target && tx_count == tx_target);
		if (busy_req) begin
			repeat (QUIET_CLKS) @(posedge sys_clk);
			check_value("tx_done count", tx_target, tx_count);
			check_value("rx_done count", rx_target, rx_count);
		end
		compare_line(line);
	endtask

	task automatic run_driver(input string name, input byte_q_t stream);
		logic [STR_W-1:0] es;
		int el;
		int rx_target;
		test_name = name;
		expected_rx(stream, es, el);
		exp_str.push_back(es);
		exp_len.push_back(el);
		rx_target = rx_count + 1;
		@(posedge sys_clk);
		#DRIVE_DELAY;
		loop_sel = 1'b0;
		foreach (stream[i]) drive_byte(stream[i]);
		wait (rx_count == rx_target);
		@(posedge sys_clk);
		#DRIVE_DELAY;
		loop_sel = 1'b1;
	endtask

	// Serial decode of uart_tx_port at the falling clock edge.
	initial begin : monitor_tx_line
		logic [7:0] b;
		forever begin
			@(negedge sys_clk);
			if (sys_rst_n && !uart_tx_port) begin
				repeat (BIT_CLKS / 2) @(negedge sys_clk);
				if (uart_tx_port) abort_run("start bit on uart_tx_port did not stay low");
				for (int i = 0; i < 8; i++) begin
					repeat (BIT_CLKS) @(negedge sys_clk);
					b[i] = uart_tx_port;
				end
				repeat (BIT_CLKS) @(negedge sys_clk);
				if (!uart_tx_port) abort_run("stop bit on uart_tx_port was low");
				tx_seen.push_back(b);
			end
		end
	end

	initial begin : compare_results
		logic [STR_W-1:0] es;
		int el;
		logic busy_q;
		busy_q = 1'b0;
		forever begin
			@(negedge sys_clk);
			if (tx_done) tx_count = tx_count + 1;
			if (rx_done) begin
				if (exp_len.size() == 0) abort_run("rx_done pulsed with no frame expected");
				es = exp_str.pop_front();
				el = exp_len.pop_front();
				// Receive busy covers the frame up to the closing delimiter.
				check_value("rx_busy before rx_done", 1, busy_q);
				check_value("rx_length", el, rx_length);
				for (int i = 0; i < el; i++) begin
					check_value($sformatf("rx_string byte %0d", i), es[8*i +: 8],
						rx_string[8*i +: 8]);
				end
				rx_count = rx_count + 1;
			end
			busy_q = rx_busy;
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge sys_clk);
			cycles = cycles + 1;
		end
		abort_run($sformatf("timeout after %0d cycles in test %s", cycles, test_name));
	end

	initial begin : run_tests
		byte_q_t content;
		int len;
		logic [7:0] c;
		tx_string = '0;
		tx_length = '0;
		tx_req = 1'b0;
		drv_line = 1'b1;
		loop_sel = 1'b1;
		sys_rst_n = 1'b1;
		seed = 36087;
		test_name = "reset";
		#1 sys_rst_n = 1'b0;
		repeat (4) @(posedge sys_clk);
		#DRIVE_DELAY;
		sys_rst_n = 1'b1;
		repeat (10) @(posedge sys_clk);

		run_loopback("hello", text_bytes("HELLO"), 1'b0);
		run_loopback("empty", text_bytes(""), 1'b0);
		run_loopback("single_delim", text_bytes("A&B"), 1'b0);
		run_driver("noise", text_bytes("xy&z&&ok&&"));
		run_loopback("busy_request", text_bytes("WORLD"), 1'b1);

		// Printable bytes with the delimiter replaced.
		for (int n = 0; n < 10; n++) begin
			content.delete();
			len = 1 + ({$random(seed)} % 20);
			for (int i = 0; i < len; i++) begin
				c = 8'h20 + 8'({$random(seed)} % 95);
				if (c == DELIM) c = 8'h2a;
				content.push_back(c);
			end
			run_loopback($sformatf("random_%0d", n), content, 1'b0);
		end

		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: test/uart_string_checker.sv
// ----------------------------------------------------------------------
// Concurrent assertions on the UART string link top-level ports.
// Bound into uart_string_handle.
// ----------------------------------------------------------------------
`default_nettype none

module uart_string_checker import uart_string_pkg::*; (
	input wire logic             sys_clk,
	input wire logic             sys_rst_n,
	input wire logic             tx_busy,
	input wire logic             tx_done,
	input wire logic             rx_busy,
	input wire logic             rx_done,
	input wire logic [LEN_W-1:0] rx_length,
	input wire logic             uart_tx_port
);
	timeunit 1ns;
	timeprecision 100ps;

	// Done strobes last a single cycle.
	tx_done_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |=> !tx_done)
		else $error("tx_done stayed high for more than one cycle");

	rx_done_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_done |=> !rx_done)
		else $error("rx_done stayed high for more than one cycle");

	// A frame ends only after a busy period.
	tx_done_after_busy: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |-> $past(tx_busy))
		else $error("tx_done without tx_busy in the previous cycle");

	// Line idles high outside a frame.
	tx_line_idle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!tx_busy |-> uart_tx_port)
		else $error("uart_tx_port low while tx_busy is low");

	reset_outputs: assert property (@(posedge sys_clk)
		!sys_rst_n |-> (!tx_busy && !tx_done && !rx_busy && !rx_done &&
			rx_length == '0 && uart_tx_port))
		else $error("an output is active while sys_rst_n is low");

endmodule

bind uart_string_handle uart_string_checker u_checker (
	.sys_clk      (sys_clk),
	.sys_rst_n    (sys_rst_n),
	.tx_busy      (tx_busy),
	.tx_done      (tx_done),
	.rx_busy      (rx_busy),
	.rx_done      (rx_done),
	.rx_length    (rx_length),
	.uart_tx_port (uart_tx_port)
);

`default_nettype wire

// File: verilog/string_framer_rx.sv
// ----------------------------------------------------------------------
// Receive framer: finds "&&" frames in the byte stream.
// Fills the string buffer and pulses done on the closing "&&".
// ----------------------------------------------------------------------
`default_nettype none

module string_framer_rx import uart_string_pkg::*; (
	input  wire logic       sys_clk,
	input  wire logic       sys_rst_n,
	input  wire logic [7:0] rx_byte,
	input  wire logic       rx_vld,
	output logic [STR_W-1:0] rx_string,
	output logic [LEN_W-1:0] rx_length,
	output logic            rx_busy,
	output logic            rx_done
);

	str_rx_state_e state;
	logic new_frame;
	logic is_frame_char;
	logic wr_one;
	logic wr_pair;
	logic [LEN_W-1:0] wr_pos;
	logic [LEN_W-1:0] pos_nxt;

	assign is_frame_char = (rx_byte == FRAME_CHAR);
	assign wr_one = (state == RX_CONTENT) && rx_vld && !is_frame_char;
	// A lone "&" inside the content, kept along with the byte after it.
	assign wr_pair = (state == RX_CLOSE1) && rx_vld && !is_frame_char;

	// Old length holds until the first write of a new frame.
	assign wr_pos = new_frame ? '0 : rx_length;
	assign pos_nxt = wr_pos + 1'b1;

	assign rx_busy = (state == RX_OPEN1) || (state == RX_CONTENT) || (state == RX_CLOSE1);
	assign rx_done = (state == RX_FINISH);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= RX_IDLE;
			new_frame <= 1'b0;
			rx_length <= '0;
		end else begin
			case (state)
				RX_IDLE: begin
					if (rx_vld && is_frame_char) begin
						state <= RX_OPEN1;
					end
				end
				RX_OPEN1: begin
					if (rx_vld) begin
						state <= is_frame_char ? RX_CONTENT : RX_IDLE;
						new_frame <= is_frame_char;
					end
				end
				RX_CONTENT: begin
					if (wr_one) begin
						rx_length <= (wr_pos < STR_BYTES) ? pos_nxt : STR_BYTES;
						new_frame <= 1'b0;
					end else if (rx_vld) begin
						state <= RX_CLOSE1;
					end
				end
				RX_CLOSE1: begin
					if (wr_pair) begin
						rx_length <= (pos_nxt < STR_BYTES) ? wr_pos + 8'd2 : STR_BYTES;
						new_frame <= 1'b0;
						state <= RX_CONTENT;
					end else if (rx_vld) begin
						// Empty frame reports length zero.
						if (new_frame) begin
							rx_length <= '0;
						end
						new_frame <= 1'b0;
						state <= RX_FINISH;
					end
				end
				RX_FINISH: state <= RX_IDLE;
				default: state <= RX_IDLE;
			endcase
		end
	end

	// String buffer, bytes past the end are dropped.
	always_ff @(posedge sys_clk) begin
		if (wr_one && wr_pos < STR_BYTES) begin
			rx_string[{wr_pos, 3'b000} +: 8] <= rx_byte;
		end
		if (wr_pair) begin
			if (wr_pos < STR_BYTES) begin
				rx_string[{wr_pos, 3'b000} +: 8] <= FRAME_CHAR;
			end
			if (pos_nxt < STR_BYTES) begin
				rx_string[{pos_nxt, 3'b000} +: 8] <= rx_byte;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/string_framer_tx.sv
// ----------------------------------------------------------------------
// Transmit framer: sends "&&", the content bytes, then "&&".
// Requests one byte at a time from the UART transmitter.
// ----------------------------------------------------------------------
`default_nettype none

module string_framer_tx import uart_string_pkg::*; (
	input  wire logic             sys_clk,
	input  wire logic             sys_rst_n,
	input  wire logic [STR_W-1:0] tx_string,
	input  wire logic [LEN_W-1:0] tx_length,
	input  wire logic             tx_req,
	input  wire logic             byte_done,
	output logic [7:0]            byte_data,
	output logic                  byte_req,
	output logic                  tx_busy,
	output logic                  tx_done
);

	str_tx_state_e state;
	logic [STR_W-1:0] str_q;
	logic [LEN_W-1:0] len_q;
	logic [LEN_W-1:0] byte_cnt;
	logic accept;

	// Finish behaves like idle for a new request.
	assign accept = tx_req && (state == TX_IDLE || state == TX_FINISH);
	assign tx_busy = (state != TX_IDLE) && (state != TX_FINISH);
	assign tx_done = (state == TX_FINISH);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= TX_IDLE;
			byte_cnt <= '0;
			byte_data <= '0;
			byte_req <= 1'b0;
		end else begin
			byte_req <= 1'b0;
			if (accept) begin
				byte_data <= FRAME_CHAR;
				byte_req <= 1'b1;
				state <= TX_OPEN1;
			end else if (state == TX_FINISH) begin
				state <= TX_IDLE;
			end else if (byte_done) begin
				byte_req <= (state != TX_CLOSE2);
				case (state)
					TX_OPEN1: begin
						byte_data <= FRAME_CHAR;
						state <= TX_OPEN2;
					end
					TX_OPEN2: begin
						if (len_q == '0) begin
							byte_data <= FRAME_CHAR;
							state <= TX_CLOSE1;
						end else begin
							byte_data <= str_q[7:0];
							byte_cnt <= 8'd1;
							state <= TX_CONTENT;
						end
					end
					TX_CONTENT: begin
						if (byte_cnt == len_q) begin
							byte_data <= FRAME_CHAR;
							state <= TX_CLOSE1;
						end else begin
							byte_data <= str_q[{byte_cnt, 3'b000} +: 8];
							byte_cnt <= byte_cnt + 1'b1;
						end
					end
					TX_CLOSE1: begin
						byte_data <= FRAME_CHAR;
						state <= TX_CLOSE2;
					end
					TX_CLOSE2: state <= TX_FINISH;
					default: state <= TX_IDLE;
				endcase
			end
		end
	end

	// Request snapshot, length clamped to the buffer size.
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			str_q <= tx_string;
			len_q <= (tx_length > STR_BYTES) ? STR_BYTES : tx_length;
		end
	end

endmodule

`default_nettype wire

// File: verilog/uart_rx.sv
// ----------------------------------------------------------------------
// UART byte receiver, 8N1, LSB first.
// Input synchronizer, start edge detect, mid-bit sampling.
// Bytes with a low stop bit are dropped.
// ----------------------------------------------------------------------
`default_nettype none

module uart_rx import uart_string_pkg::*; (
	input  wire logic       sys_clk,
	input  wire logic       sys_rst_n,
	input  wire logic       rx,
	output logic [7:0]      rx_byte,
	output logic            rx_vld
);

	uart_state_e state;
	logic rx_meta;
	logic rx_sync;
	logic rx_last;
	logic [BAUD_CNT_W-1:0] clk_cnt;
	logic [2:0] bit_cnt;
	logic [7:0] shift;
	logic start_edge;
	logic bit_end;
	logic half_bit;
	logic sample_data;
	logic sample_stop;

	assign start_edge = rx_last && !rx_sync;
	assign bit_end = (clk_cnt == CLKS_PER_BIT - 1'b1);
	assign half_bit = (clk_cnt == (CLKS_PER_BIT >> 1));
	assign sample_data = (state == UART_DATA) && bit_end;
	assign sample_stop = (state == UART_STOP) && bit_end;

	// Two-flop synchronizer plus one stage for edge detect.
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_last <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_last <= rx_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= UART_IDLE;
			clk_cnt <= '0;
			bit_cnt <= '0;
			rx_vld <= 1'b0;
		end else begin
			rx_vld <= 1'b0;
			clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
			case (state)
				UART_IDLE: begin
					clk_cnt <= '0;
					if (start_edge) begin
						state <= UART_START;
					end
				end
				UART_START: begin
					// Recheck at mid-bit; a glitch goes back to idle.
					if (half_bit) begin
						clk_cnt <= '0;
						bit_cnt <= '0;
						state <= rx_sync ? UART_IDLE : UART_DATA;
					end
				end
				UART_DATA: begin
					if (bit_end) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7) begin
							state <= UART_STOP;
						end
					end
				end
				UART_STOP: begin
					if (bit_end) begin
						rx_vld <= rx_sync;
						state <= UART_IDLE;
					end
				end
				default: state <= UART_IDLE;
			endcase
		end
	end

	// Received data path.
	always_ff @(posedge sys_clk) begin
		if (sample_data) begin
			shift <= {rx_sync, shift[7:1]};
		end
		if (sample_stop && rx_sync) begin
			rx_byte <= shift;
		end
	end

endmodule

`default_nettype wire

// File: verilog/uart_string_handle.sv
// ----------------------------------------------------------------------
// UART string link top level.
// Transmit framer into the UART transmitter, and the UART
// receiver into the receive framer.
// ----------------------------------------------------------------------
`default_nettype none

module uart_string_handle import uart_string_pkg::*; (
	input  wire logic             sys_clk,
	input  wire logic             sys_rst_n,

	input  wire logic [STR_W-1:0] tx_string,
	input  wire logic [LEN_W-1:0] tx_length,
	input  wire logic             tx_req,
	output logic                  tx_busy,
	output logic                  tx_done,

	output logic [STR_W-1:0]      rx_string,
	output logic [LEN_W-1:0]      rx_length,
	output logic                  rx_busy,
	output logic                  rx_done,

	input  wire logic             uart_rx_port,
	output logic                  uart_tx_port
);

	// Byte link between the transmit framer and the UART.
	logic [7:0] byte_data;
	logic byte_req;
	logic byte_done;

	// Byte stream from the UART receiver.
	logic [7:0] rx_byte;
	logic rx_vld;

	string_framer_tx u_framer_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_string (tx_string),
		.tx_length (tx_length),
		.tx_req    (tx_req),
		.byte_done (byte_done),
		.byte_data (byte_data),
		.byte_req  (byte_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done)
	);

	uart_tx u_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_data (byte_data),
		.byte_req  (byte_req),
		.tx        (uart_tx_port),
		.byte_done (byte_done)
	);

	uart_rx u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (uart_rx_port),
		.rx_byte   (rx_byte),
		.rx_vld    (rx_vld)
	);

	string_framer_rx u_framer_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_byte   (rx_byte),
		.rx_vld    (rx_vld),
		.rx_string (rx_string),
		.rx_length (rx_length),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done)
	);

endmodule

`default_nettype wire

// File: verilog/uart_string_pkg.sv
// ----------------------------------------------------------------------
// Shared constants and state types for the UART string link.
// String buffer sizes, serial bit timing, the frame delimiter
// and the FSM state encodings of the byte and string layers.
// ----------------------------------------------------------------------
`default_nettype none

package uart_string_pkg;

	// String buffer geometry, byte k at bits 8k+7 down to 8k.
	localparam logic [7:0] STR_BYTES = 8'd137;
	localparam int STR_W = 1096;
	localparam int LEN_W = 8;

	// 115200 baud from a 10 MHz sys_clk.
	localparam int BAUD_CNT_W = 7;
	localparam logic [BAUD_CNT_W-1:0] CLKS_PER_BIT = 7'd87;
	localparam int TX_STOP_BITS = 2;

	// Delimiter, sent twice on each side of the content.
	localparam logic [7:0] FRAME_CHAR = 8'h26;

	typedef enum logic [1:0] {
		UART_IDLE,
		UART_START,
		UART_DATA,
		UART_STOP
	} uart_state_e;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_OPEN1,
		TX_OPEN2,
		TX_CONTENT,
		TX_CLOSE1,
		TX_CLOSE2,
		TX_FINISH
	} str_tx_state_e;

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_OPEN1,
		RX_CONTENT,
		RX_CLOSE1,
		RX_FINISH
	} str_rx_state_e;

endpackage

`default_nettype wire

// File: verilog/uart_tx.sv
// ----------------------------------------------------------------------
// UART byte transmitter, 8N2, LSB first.
// One byte per request, done pulse after the last stop bit.
// ----------------------------------------------------------------------
`default_nettype none

module uart_tx import uart_string_pkg::*; (
	input  wire logic       sys_clk,
	input  wire logic       sys_rst_n,
	input  wire logic [7:0] byte_data,
	input  wire logic       byte_req,
	output logic            tx,
	output logic            byte_done
);

	uart_state_e state;
	logic [BAUD_CNT_W-1:0] clk_cnt;
	logic [2:0] bit_cnt;
	logic [7:0] shift;
	logic bit_end;

	assign bit_end = (clk_cnt == CLKS_PER_BIT - 1'b1);

	// Bit timing and line control.
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= UART_IDLE;
			clk_cnt <= '0;
			bit_cnt <= '0;
			tx <= 1'b1;
			byte_done <= 1'b0;
		end else begin
			byte_done <= 1'b0;
			if (state != UART_IDLE) begin
				clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
			end
			case (state)
				UART_IDLE: begin
					clk_cnt <= '0;
					if (byte_req) begin
						tx <= 1'b0;
						state <= UART_START;
					end
				end
				UART_START: begin
					if (bit_end) begin
						tx <= shift[0];
						bit_cnt <= '0;
						state <= UART_DATA;
					end
				end
				UART_DATA: begin
					if (bit_end) begin
						if (bit_cnt == 3'd7) begin
							// First stop bit.
							tx <= 1'b1;
							bit_cnt <= '0;
							state <= UART_STOP;
						end else begin
							tx <= shift[1];
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				UART_STOP: begin
					if (bit_end) begin
						if (bit_cnt == 3'(TX_STOP_BITS - 1)) begin
							byte_done <= 1'b1;
							state <= UART_IDLE;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				default: state <= UART_IDLE;
			endcase
		end
	end

	// Shift register, shifts once per data bit.
	always_ff @(posedge sys_clk) begin
		if (state == UART_IDLE && byte_req) begin
			shift <= byte_data;
		end else if (state == UART_DATA && bit_end) begin
			shift <= {1'b0, shift[7:1]};
		end
	end

endmodule

`default_nettype wire
